/* cart_loader/cheat_code_assembler.sv */
// Cheat code assembly from eight-word download records with completion strobe
`timescale 1ns/1ps
`default_nettype none

module cheat_code_assembler (
	input  logic                                 clk_sys,
	input  logic                                 reset,
	input  logic                                 cart_download,
	input  logic                                 code_download,
	input  logic                                 ioctl_wr,
	input  logic [cart_pkg::IOCTL_ADDR_BITS-1:0] ioctl_addr,
	input  logic [cart_pkg::IOCTL_DATA_BITS-1:0] ioctl_dout,
	output cart_pkg::cheat_code_t                cheat_code,
	output logic                                 cheat_valid,
	output logic                                 cheat_reset
);

	logic       code_wr;
	logic [3:0] word_ofs;

	assign code_wr  = code_download && ioctl_wr;
	assign word_ofs = ioctl_addr[3:0];

	// Low half of each field arrives first
	always_ff @(posedge clk_sys) begin
		if (code_wr) begin
			case (word_ofs)
				4'd0:  cheat_code.flags[15:0]    <= ioctl_dout;
				4'd2:  cheat_code.flags[31:16]   <= ioctl_dout;
				4'd4:  cheat_code.address[15:0]  <= ioctl_dout;
				4'd6:  cheat_code.address[31:16] <= ioctl_dout;
				4'd8:  cheat_code.compare[15:0]  <= ioctl_dout;
				4'd10: cheat_code.compare[31:16] <= ioctl_dout;
				4'd12: cheat_code.replace[15:0]  <= ioctl_dout;
				4'd14: cheat_code.replace[31:16] <= ioctl_dout;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cheat_valid <= 1'b0;
			cheat_reset <= 1'b0;
		end else begin
			// Last word of the record
			cheat_valid <= code_wr && (word_ofs == 4'd14);
			// New code list or new cartridge drops the old codes
			cheat_reset <= (code_wr && ioctl_addr == '0) || cart_download;
		end
	end

	cheat_valid_single: assert property (
		@(posedge clk_sys) disable iff (reset) cheat_valid |=> !cheat_valid
	);

endmodule

`default_nettype wire

/* cart_loader/ram_clear_sequencer.sv */
// Work-RAM and audio-RAM clear sweep with power-on fill pattern generation
`timescale 1ns/1ps
`default_nettype none

module ram_clear_sequencer (
	input  logic                                clk_sys,
	input  logic                                reset,
	input  logic                                cart_download,
	input  cart_pkg::fill_pattern_e             wram_pattern,
	input  cart_pkg::fill_pattern_e             aram_pattern,
	output logic                                clear_busy,
	output logic                                fill_wr,
	output logic [cart_pkg::FILL_ADDR_BITS-1:0] fill_addr,
	output logic [7:0]                          wram_fill_data,
	output logic [7:0]                          aram_fill_data
);

	logic cart_download_q;
	logic start_sweep;

	// Pattern byte for one address
	function automatic logic [7:0] fill_byte(
		input cart_pkg::fill_pattern_e     pattern,
		input logic [cart_pkg::FILL_ADDR_BITS-1:0] addr
	);
		logic [7:0] data;
		case (pattern)
			cart_pkg::FILL_9966: data = (addr[8] ^ addr[2]) ? 8'h66 : 8'h99;
			cart_pkg::FILL_00FF: data = (addr[9] ^ addr[0]) ? 8'hFF : 8'h00;
			cart_pkg::FILL_55:   data = 8'h55;
			default:             data = 8'hFF;
		endcase
		return data;
	endfunction

	// ========================================================================
	// Sweep control
	// ========================================================================

	// Only a fresh download start begins a sweep
	assign start_sweep = cart_download && !cart_download_q && !clear_busy;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cart_download_q <= 1'b0;
			clear_busy      <= 1'b0;
			fill_addr       <= '0;
		end else begin
			cart_download_q <= cart_download;

			if (start_sweep) begin
				clear_busy <= 1'b1;
			end else if (clear_busy && (&fill_addr)) begin
				clear_busy <= 1'b0;
			end

			// Wraps back to zero on the last write
			if (clear_busy) begin
				fill_addr <= fill_addr + 1'b1;
			end else begin
				fill_addr <= '0;
			end
		end
	end

	assign fill_wr = clear_busy;

	// ========================================================================
	// Fill data
	// ========================================================================

	assign wram_fill_data = fill_byte(wram_pattern, fill_addr);
	assign aram_fill_data = fill_byte(aram_pattern, fill_addr);

	fill_addr_steps: assert property (
		@(posedge clk_sys) disable iff (reset)
		clear_busy ##1 clear_busy |-> fill_addr == $past(fill_addr) + 1'b1
	);

endmodule

`default_nettype wire

/* cart_loader/rom_header_parser.sv */
// ROM header parser producing mapper type, ROM and save-RAM masks and video region
`timescale 1ns/1ps
`default_nettype none

module rom_header_parser (
	input  logic                                  clk_sys,
	input  logic                                  reset,
	input  logic                                  cart_download,
	input  logic                                  ioctl_wr,
	input  logic [cart_pkg::IOCTL_ADDR_BITS-1:0]  ioctl_addr,
	input  logic [cart_pkg::IOCTL_DATA_BITS-1:0]  ioctl_dout,
	input  cart_pkg::header_mode_e                header_mode,
	input  cart_pkg::region_sel_e                 region_sel,
	output logic [7:0]                            rom_type,
	output logic [cart_pkg::MASK_BITS-1:0]        rom_mask,
	output logic [cart_pkg::MASK_BITS-1:0]        ram_mask,
	output logic                                  pal
);

	logic [3:0] rom_size;
	logic [3:0] ram_size;
	logic       rom_region;

	// Size field addresses of the forced mapper
	logic                                 forced_map;
	logic [cart_pkg::IOCTL_ADDR_BITS-1:0] rom_field_addr;
	logic [cart_pkg::IOCTL_ADDR_BITS-1:0] ram_field_addr;

	logic hdr_wr;

	assign hdr_wr = cart_download && ioctl_wr;

	always_comb begin
		forced_map     = 1'b1;
		rom_field_addr = '0;
		case (header_mode)
			cart_pkg::LOROM:
				rom_field_addr = cart_pkg::LOROM_HDR_BASE + cart_pkg::HEADER_SKIP;
			cart_pkg::HIROM:
				rom_field_addr = cart_pkg::HIROM_HDR_BASE + cart_pkg::HEADER_SKIP;
			cart_pkg::EXHIROM:
				rom_field_addr = cart_pkg::EXHIROM_HDR_BASE + cart_pkg::HEADER_SKIP;
			default:
				forced_map = 1'b0;
		endcase
		ram_field_addr = rom_field_addr + cart_pkg::RAM_FIELD_OFS;
	end

	// ========================================================================
	// Header capture
	// ========================================================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rom_type   <= 8'd0;
			rom_size   <= cart_pkg::DEFAULT_ROM_SIZE;
			ram_size   <= 4'd0;
			rom_region <= 1'b0;
		end else if (hdr_wr) begin
			// Word 0 carries the loader's own size byte and mapper type
			if (ioctl_addr == '0) begin
				rom_size <= cart_pkg::DEFAULT_ROM_SIZE;
				ram_size <= 4'd0;
				if (header_mode == cart_pkg::AUTO && ioctl_dout[7:0] != 8'd0) begin
					{ram_size, rom_size} <= ioctl_dout[7:0];
				end
				case (header_mode)
					cart_pkg::NO_HEADER: rom_type <= 8'd0;
					cart_pkg::LOROM:     rom_type <= 8'd0;
					cart_pkg::HIROM:     rom_type <= 8'd1;
					cart_pkg::EXHIROM:   rom_type <= 8'd2;
					default:             rom_type <= ioctl_dout[15:8];
				endcase
			end

			if (ioctl_addr == cart_pkg::IOCTL_ADDR_BITS'(2)) begin
				rom_region <= ioctl_dout[8];
			end

			// Internal header of the cartridge itself
			if (forced_map) begin
				if (ioctl_addr == rom_field_addr) begin
					rom_size <= ioctl_dout[11:8];
				end
				if (ioctl_addr == ram_field_addr) begin
					ram_size <= ioctl_dout[3:0];
				end
			end
		end
	end

	// Address masks from the size codes
	assign rom_mask = (cart_pkg::MASK_UNIT << rom_size) - 1'b1;
	assign ram_mask = (ram_size != 4'd0) ? ((cart_pkg::MASK_UNIT << ram_size) - 1'b1) : '0;

	// Region only switches once the download is over
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			pal <= 1'b0;
		end else if (!cart_download) begin
			if (region_sel == cart_pkg::REGION_AUTO) begin
				pal <= rom_region;
			end else begin
				pal <= (region_sel == cart_pkg::REGION_PAL);
			end
		end
	end

	rom_mask_nonzero: assert property (
		@(posedge clk_sys) disable iff (reset) rom_mask != '0
	);

endmodule

`default_nettype wire

/* common/cart_pkg.sv */
// Shared widths, header offsets, mode enums and the cheat code layout
`default_nettype none

package cart_pkg;

	// ========================================================================
	// Download stream
	// ========================================================================

	localparam int IOCTL_ADDR_BITS = 25;
	localparam int IOCTL_DATA_BITS = 16;

	// ========================================================================
	// ROM header layout
	// ========================================================================

	localparam int MASK_BITS = 24;

	// Copier header in front of the ROM image
	localparam logic [IOCTL_ADDR_BITS-1:0] HEADER_SKIP = 25'd512;

	// Size field location per mapper without the copier header
	localparam logic [IOCTL_ADDR_BITS-1:0] LOROM_HDR_BASE   = 25'h000_7FD6;
	localparam logic [IOCTL_ADDR_BITS-1:0] HIROM_HDR_BASE   = 25'h000_FFD6;
	localparam logic [IOCTL_ADDR_BITS-1:0] EXHIROM_HDR_BASE = 25'h040_FFD6;

	// RAM size field follows the ROM size field
	localparam logic [IOCTL_ADDR_BITS-1:0] RAM_FIELD_OFS = 25'd2;

	localparam logic [3:0] DEFAULT_ROM_SIZE = 4'd12;

	// Smallest mask unit is 1 KiB
	localparam logic [MASK_BITS-1:0] MASK_UNIT = 24'd1024;

	// ========================================================================
	// RAM clear
	// ========================================================================

	// 128 KiB sweep
	localparam int FILL_ADDR_BITS = 17;

	// ========================================================================
	// Mode selects
	// ========================================================================

	typedef enum logic [2:0] {
		AUTO      = 3'd0,
		NO_HEADER = 3'd1,
		LOROM     = 3'd2,
		HIROM     = 3'd3,
		EXHIROM   = 3'd4
	} header_mode_e;

	typedef enum logic [1:0] {
		REGION_AUTO = 2'd0,
		REGION_NTSC = 2'd1,
		REGION_PAL  = 2'd2
	} region_sel_e;

	// Power-on patterns of the different console revisions
	typedef enum logic [1:0] {
		FILL_9966 = 2'd0,
		FILL_00FF = 2'd1,
		FILL_55   = 2'd2,
		FILL_FF   = 2'd3
	} fill_pattern_e;

	// Cheat code record as delivered by the loader
	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] address;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_code_t;

endpackage

`default_nettype wire

/* project.f */
common/cart_pkg.sv
cart_loader/rom_header_parser.sv
cart_loader/ram_clear_sequencer.sv
cart_loader/cheat_code_assembler.sv
verilog/cart_loader_top.sv
verification/cart_loader_tb.sv

/* run_sim.sh */
#!/bin/sh
# Compile the cart loader testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --assert --top-module cart_loader_tb -f project.f -o cart_loader_sim

output=$(./obj_dir/cart_loader_sim)
echo "$output"

if echo "$output" | grep -q "^Test OK$"; then
	exit 0
fi
exit 1

/* verification/cart_loader_tb.sv */
// Testbench for the cart loader top with header table, RAM clear sweep and cheat code checks
`timescale 1ns/1ps
`default_nettype none

module cart_loader_tb;

	localparam int NUM_CASES = 7;
	localparam int MAX_WR    = 6;
	localparam int SWEEP_LEN = 1 << cart_pkg::FILL_ADDR_BITS;

	typedef struct packed {
		cart_pkg::header_mode_e                           mode;
		cart_pkg::region_sel_e                            region;
		logic [2:0]                                       n_wr;
		logic [MAX_WR-1:0][cart_pkg::IOCTL_ADDR_BITS-1:0] addr;
		logic [MAX_WR-1:0][15:0]                          data;
		logic [7:0]                                       rom_type;
		logic [cart_pkg::MASK_BITS-1:0]                   rom_mask;
		logic [cart_pkg::MASK_BITS-1:0]                   ram_mask;
		logic                                             pal;
	} header_case_t;

	logic                                 clk_sys = 1'b0;
	logic                                 reset;
	logic                                 ioctl_download;
	logic [7:0]                           ioctl_index;
	logic                                 ioctl_wr;
	logic [cart_pkg::IOCTL_ADDR_BITS-1:0] ioctl_addr;
	logic [cart_pkg::IOCTL_DATA_BITS-1:0] ioctl_dout;
	cart_pkg::header_mode_e               header_mode;
	cart_pkg::region_sel_e                region_sel;
	cart_pkg::fill_pattern_e              wram_pattern;
	cart_pkg::fill_pattern_e              aram_pattern;
	logic [7:0]                           rom_type;
	logic [cart_pkg::MASK_BITS-1:0]       rom_mask;
	logic [cart_pkg::MASK_BITS-1:0]       ram_mask;
	logic                                 pal;
	logic                                 clear_busy;
	logic                                 fill_wr;
	logic [cart_pkg::FILL_ADDR_BITS-1:0]  fill_addr;
	logic [7:0]                           wram_fill_data;
	logic [7:0]                           aram_fill_data;
	cart_pkg::cheat_code_t                cheat_code;
	logic                                 cheat_valid;
	logic                                 cheat_reset;

	header_case_t          cases [NUM_CASES];
	int                    case_count = 0;
	int                    errors = 0;
	int                    test_errors = 0;
	int                    tests_run = 0;
	int                    tests_failed = 0;
	int                    pulse_count;
	cart_pkg::cheat_code_t got_code;

	always #2 clk_sys = ~clk_sys;

	cart_loader_top dut_i (.*);

	// Power-on byte expected at one address of the sweep
	function automatic logic [7:0] expected_fill(input cart_pkg::fill_pattern_e pat,
			input logic [cart_pkg::FILL_ADDR_BITS-1:0] a);
		logic [7:0] v;
		v = 8'hFF;
		if (pat == cart_pkg::FILL_9966) begin
			v = (a[8] != a[2]) ? 8'h66 : 8'h99;
		end else if (pat == cart_pkg::FILL_00FF) begin
			v = (a[9] != a[0]) ? 8'hFF : 8'h00;
		end else if (pat == cart_pkg::FILL_55) begin
			v = 8'h55;
		end
		return v;
	endfunction

	task automatic check_value(input string what, input logic [31:0] got,
			input logic [31:0] exp);
		assert (got === exp) else begin
			$display("mismatch at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (errors == test_errors) begin
			$display("PASS  %s", name);
		end else begin
			$display("FAIL  %s", name);
			tests_failed++;
		end
		test_errors = errors;
	endtask

	task automatic new_case(input cart_pkg::header_mode_e mode, input cart_pkg::region_sel_e region,
			input logic [7:0] type_exp, input logic [23:0] rom_exp, input logic [23:0] ram_exp,
			input logic pal_exp);
		cases[case_count].mode     = mode;
		cases[case_count].region   = region;
		cases[case_count].n_wr     = 3'd0;
		cases[case_count].rom_type = type_exp;
		cases[case_count].rom_mask = rom_exp;
		cases[case_count].ram_mask = ram_exp;
		cases[case_count].pal      = pal_exp;
		case_count++;
	endtask

	task automatic add_write(input logic [cart_pkg::IOCTL_ADDR_BITS-1:0] addr,
			input logic [15:0] data);
		int i;
		i = case_count - 1;
		cases[i].addr[cases[i].n_wr] = addr;
		cases[i].data[cases[i].n_wr] = data;
		cases[i].n_wr = cases[i].n_wr + 3'd1;
	endtask

	// One-cycle write strobe that returns on the next falling edge
	task automatic write_word(input logic [cart_pkg::IOCTL_ADDR_BITS-1:0] addr,
			input logic [15:0] data);
		ioctl_addr = addr;
		ioctl_dout = data;
		ioctl_wr   = 1'b1;
		@(negedge clk_sys);
		ioctl_wr   = 1'b0;
	endtask

	task automatic count_cheat_pulse;
		if (cheat_valid) begin
			pulse_count++;
			got_code = cheat_code;
		end
	endtask

	task automatic wait_clear_idle;
		int waited;
		waited = 0;
		while (clear_busy && waited < SWEEP_LEN + 16) begin
			@(negedge clk_sys);
			waited++;
		end
		assert (!clear_busy) else begin
			$display("error at %0t ns: RAM clear sweep never finished", $time);
			errors++;
		end
	endtask

	// ========================================================================
	// Header table row
	// ========================================================================

	task automatic run_header_case(input int i);
		header_case_t c;
		logic         pal_before;
		logic [31:0]  rnd;
		c = cases[i];
		header_mode = c.mode;
		region_sel  = c.region;
		repeat (2) @(negedge clk_sys);
		pal_before = pal;
		ioctl_index    = 8'h00;
		ioctl_download = 1'b1;
		@(negedge clk_sys);
		for (int w = 0; w < int'(c.n_wr); w++) begin
			write_word(c.addr[w], c.data[w]);
		end
		// Filler words away from every header field
		for (int w = 0; w < 4; w++) begin
			rnd = $urandom;
			write_word(25'h100 + 25'(2 * w), rnd[15:0]);
		end
		check_value("pal during download", 32'(pal), 32'(pal_before));
		ioctl_download = 1'b0;
		repeat (2) @(negedge clk_sys);
		check_value("rom_type", 32'(rom_type), 32'(c.rom_type));
		check_value("rom_mask", 32'(rom_mask), 32'(c.rom_mask));
		check_value("ram_mask", 32'(ram_mask), 32'(c.ram_mask));
		check_value("pal", 32'(pal), 32'(c.pal));
		end_test($sformatf("header row %0d", i));
	endtask

	// ========================================================================
	// RAM clear sweep
	// ========================================================================

	task automatic run_sweep(input cart_pkg::fill_pattern_e wpat,
			input cart_pkg::fill_pattern_e apat);
		int                                  count;
		int                                  waited;
		logic [cart_pkg::FILL_ADDR_BITS-1:0] exp_addr;
		wait_clear_idle();
		wram_pattern   = wpat;
		aram_pattern   = apat;
		ioctl_index    = 8'hC0;
		ioctl_download = 1'b1;
		count  = 0;
		waited = 0;
		@(negedge clk_sys);
		while (!clear_busy && waited < 8) begin
			@(negedge clk_sys);
			waited++;
		end
		assert (clear_busy) else begin
			$display("error at %0t ns: clear_busy did not rise after the download start", $time);
			errors++;
		end
		check_value("cheat_reset in cart download", 32'(cheat_reset), 32'd1);
		while (clear_busy && count < SWEEP_LEN + 8) begin
			exp_addr = count[cart_pkg::FILL_ADDR_BITS-1:0];
			check_value("fill_wr", 32'(fill_wr), 32'd1);
			check_value("fill_addr", 32'(fill_addr), 32'(exp_addr));
			check_value("wram_fill_data", 32'(wram_fill_data), 32'(expected_fill(wpat, exp_addr)));
			check_value("aram_fill_data", 32'(aram_fill_data), 32'(expected_fill(apat, exp_addr)));
			count++;
			@(negedge clk_sys);
		end
		check_value("fill write count", 32'(count), 32'(SWEEP_LEN));
		check_value("clear_busy after sweep", 32'(clear_busy), 32'd0);
		check_value("fill_wr after sweep", 32'(fill_wr), 32'd0);
		ioctl_download = 1'b0;
		@(negedge clk_sys);
		end_test($sformatf("RAM clear %s/%s", wpat.name(), apat.name()));
	endtask

	// ========================================================================
	// Cheat code record
	// ========================================================================

	task automatic run_cheat(input int k);
		logic [15:0]           words [8];
		logic [31:0]           rnd;
		cart_pkg::cheat_code_t exp_code;
		int                    waited;
		for (int w = 0; w < 8; w++) begin
			rnd = $urandom;
			words[w] = rnd[15:0];
		end
		exp_code.flags   = {words[1], words[0]};
		exp_code.address = {words[3], words[2]};
		exp_code.compare = {words[5], words[4]};
		exp_code.replace = {words[7], words[6]};
		pulse_count    = 0;
		ioctl_index    = 8'hFF;
		ioctl_download = 1'b1;
		@(negedge clk_sys);
		for (int w = 0; w < 8; w++) begin
			write_word(25'(16 * k + 2 * w), words[w]);
			if (k == 0 && w == 0) begin
				check_value("cheat_reset after code write", 32'(cheat_reset), 32'd1);
			end
			if (k == 0 && w == 1) begin
				check_value("cheat_reset after later code write", 32'(cheat_reset), 32'd0);
			end
			count_cheat_pulse();
		end
		waited = 0;
		while (pulse_count == 0 && waited < 8) begin
			@(negedge clk_sys);
			waited++;
			count_cheat_pulse();
		end
		assert (pulse_count != 0) else begin
			$display("error at %0t ns: cheat_valid never pulsed", $time);
			errors++;
		end
		// No second strobe may follow
		repeat (3) begin
			@(negedge clk_sys);
			count_cheat_pulse();
		end
		check_value("cheat_valid pulses", 32'(pulse_count), 32'd1);
		assert (got_code === exp_code) else begin
			$display("mismatch at %0t ns: cheat_code is %h, expected %h", $time, got_code, exp_code);
			errors++;
		end
		ioctl_download = 1'b0;
		@(negedge clk_sys);
		end_test($sformatf("cheat code %0d", k));
	endtask

	initial begin
		void'($urandom(32'h073e_c265));
		reset          = 1'b1;
		ioctl_download = 1'b0;
		ioctl_index    = 8'h00;
		ioctl_wr       = 1'b0;
		ioctl_addr     = '0;
		ioctl_dout     = '0;
		header_mode    = cart_pkg::AUTO;
		region_sel     = cart_pkg::REGION_AUTO;
		wram_pattern   = cart_pkg::FILL_9966;
		aram_pattern   = cart_pkg::FILL_00FF;

		// Mode, region, expected type, ROM mask, RAM mask, pal, then the header words
		new_case(cart_pkg::AUTO, cart_pkg::REGION_AUTO, 8'h01, 24'h0F_FFFF, 24'h00_1FFF, 1'b1);
		add_write(25'h0, 16'h013A);
		add_write(25'h2, 16'h0100);
		new_case(cart_pkg::AUTO, cart_pkg::REGION_AUTO, 8'h02, 24'h1F_FFFF, 24'h00_0000, 1'b0);
		add_write(25'h0, 16'h020B);
		add_write(25'h2, 16'h0000);
		new_case(cart_pkg::AUTO, cart_pkg::REGION_AUTO, 8'h35, 24'h3F_FFFF, 24'h00_0000, 1'b0);
		add_write(25'h0, 16'h3500);
		add_write(25'h2, 16'h00FF);
		add_write(25'h81D6, 16'h0900);
		new_case(cart_pkg::LOROM, cart_pkg::REGION_AUTO, 8'h00, 24'h07_FFFF, 24'h00_0FFF, 1'b1);
		add_write(25'h0, 16'h1234);
		add_write(25'h2, 16'h0100);
		add_write(25'h81D6, 16'h0900);
		add_write(25'h81D8, 16'h0002);
		add_write(25'h101D6, 16'h0B00);
		new_case(cart_pkg::HIROM, cart_pkg::REGION_NTSC, 8'h01, 24'h0F_FFFF, 24'h00_7FFF, 1'b0);
		add_write(25'h0, 16'h0000);
		add_write(25'h2, 16'h0100);
		add_write(25'h101D6, 16'h0A00);
		add_write(25'h101D8, 16'h0005);
		add_write(25'h81D6, 16'h0800);
		new_case(cart_pkg::EXHIROM, cart_pkg::REGION_PAL, 8'h02, 24'h7F_FFFF, 24'h00_1FFF, 1'b1);
		add_write(25'h0, 16'h0000);
		add_write(25'h2, 16'h0000);
		add_write(25'h4101D6, 16'h0D00);
		add_write(25'h4101D8, 16'h0003);
		add_write(25'h101D6, 16'h0800);
		add_write(25'h101D8, 16'h0007);
		new_case(cart_pkg::NO_HEADER, cart_pkg::REGION_AUTO, 8'h00, 24'h3F_FFFF, 24'h00_0000, 1'b0);
		add_write(25'h0, 16'h7F5A);
		add_write(25'h2, 16'h0000);

		repeat (4) @(negedge clk_sys);
		reset = 1'b0;
		@(negedge clk_sys);

		check_value("rom_type after reset", 32'(rom_type), 32'd0);
		check_value("rom_mask after reset", 32'(rom_mask), 32'h3F_FFFF);
		check_value("ram_mask after reset", 32'(ram_mask), 32'd0);
		check_value("pal after reset", 32'(pal), 32'd0);
		check_value("clear_busy after reset", 32'(clear_busy), 32'd0);
		check_value("fill_wr after reset", 32'(fill_wr), 32'd0);
		check_value("cheat_valid after reset", 32'(cheat_valid), 32'd0);
		check_value("cheat_reset after reset", 32'(cheat_reset), 32'd0);
		end_test("reset state");

		for (int i = 0; i < case_count; i++) begin
			run_header_case(i);
		end
		run_sweep(cart_pkg::FILL_9966, cart_pkg::FILL_00FF);
		run_sweep(cart_pkg::FILL_55, cart_pkg::FILL_FF);
		for (int k = 0; k < 4; k++) begin
			run_cheat(k);
		end

		$display("%0d tests run, %0d passed, %0d failed, %0d errors",
			tests_run, tests_run - tests_failed, tests_failed, errors);
		if (errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* verilog/cart_loader_top.sv */
// Cart loader top with download index decode, header parser, RAM clear and cheats
`timescale 1ns/1ps
`default_nettype none

module cart_loader_top (
	input  logic                                 clk_sys,
	input  logic                                 reset,
	input  logic                                 ioctl_download,
	input  logic [7:0]                           ioctl_index,
	input  logic                                 ioctl_wr,
	input  logic [cart_pkg::IOCTL_ADDR_BITS-1:0] ioctl_addr,
	input  logic [cart_pkg::IOCTL_DATA_BITS-1:0] ioctl_dout,
	input  cart_pkg::header_mode_e               header_mode,
	input  cart_pkg::region_sel_e                region_sel,
	input  cart_pkg::fill_pattern_e              wram_pattern,
	input  cart_pkg::fill_pattern_e              aram_pattern,
	output logic [7:0]                           rom_type,
	output logic [cart_pkg::MASK_BITS-1:0]       rom_mask,
	output logic [cart_pkg::MASK_BITS-1:0]       ram_mask,
	output logic                                 pal,
	output logic                                 clear_busy,
	output logic                                 fill_wr,
	output logic [cart_pkg::FILL_ADDR_BITS-1:0]  fill_addr,
	output logic [7:0]                           wram_fill_data,
	output logic [7:0]                           aram_fill_data,
	output cart_pkg::cheat_code_t                cheat_code,
	output logic                                 cheat_valid,
	output logic                                 cheat_reset
);

	logic cart_download;
	logic code_download;

	// ========================================================================
	// Download index decode
	// ========================================================================

	// Cartridge images use index 0 in the low six bits, codes use all ones
	assign cart_download = ioctl_download && (ioctl_index[5:0] == 6'd0);
	assign code_download = ioctl_download && (&ioctl_index);

	// ========================================================================
	// Loader blocks
	// ========================================================================

	rom_header_parser header_i (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.cart_download (cart_download),
		.ioctl_wr      (ioctl_wr),
		.ioctl_addr    (ioctl_addr),
		.ioctl_dout    (ioctl_dout),
		.header_mode   (header_mode),
		.region_sel    (region_sel),
		.rom_type      (rom_type),
		.rom_mask      (rom_mask),
		.ram_mask      (ram_mask),
		.pal           (pal)
	);

	ram_clear_sequencer clear_i (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.cart_download  (cart_download),
		.wram_pattern   (wram_pattern),
		.aram_pattern   (aram_pattern),
		.clear_busy     (clear_busy),
		.fill_wr        (fill_wr),
		.fill_addr      (fill_addr),
		.wram_fill_data (wram_fill_data),
		.aram_fill_data (aram_fill_data)
	);

	cheat_code_assembler cheat_i (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.cart_download (cart_download),
		.code_download (code_download),
		.ioctl_wr      (ioctl_wr),
		.ioctl_addr    (ioctl_addr),
		.ioctl_dout    (ioctl_dout),
		.cheat_code    (cheat_code),
		.cheat_valid   (cheat_valid),
		.cheat_reset   (cheat_reset)
	);

endmodule

`default_nettype wire
